/* stageOneCtrl.f */
+incdir+bench
design/stageOnePkg.sv
design/instrDecode.sv
design/cacheWait.sv
design/stageSequencer.sv
design/ctrlWordGen.sv
design/stageOneCtrl.sv
bench/stageOneCtrlTb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= stageOneCtrl.f
TB_TOP    ?= stageOneCtrlTb
RTL_TOP   ?= stageOneCtrl
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP) $(VFLAGS)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP) $(VFLAGS)

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) $(VFLAGS)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/stageOneModel.svh */
`ifndef STAGE_ONE_MODEL_SVH
`define STAGE_ONE_MODEL_SVH

// How a step of the expected sequence ends
typedef enum logic [2:0] {endOne, endCache, endInRdy, endOutRdy, endOutRecv} stepEndT;

typedef struct packed {
	ctrlWordT word;     // Held through the whole step
	logic     inPulse;
	stepEndT  stepEnd;
} stepT;

typedef struct packed {
	stepT [4:0] steps;
	logic [2:0] count;
} expListT;

function automatic stepT waitStep(input stepEndT stepEnd);
	stepT s;
	s = '0;
	s.stepEnd = stepEnd;
	return s;
endfunction

function automatic stepT memStep(input logic isWrite, input logic fromIr, input logic inSel);
	stepT s;
	s = waitStep(endCache);
	s.word.memRead    = !isWrite;
	s.word.memWrite   = isWrite;
	s.word.addrFromIr = fromIr;
	s.word.inSelect   = inSel;
	return s;
endfunction

function automatic expListT appendStep(input expListT l, input stepT s);
	expListT r;
	r = l;
	r.steps[r.count] = s;
	r.count = r.count + 3'd1;
	return r;
endfunction

function automatic aluOpT aluFor(input opcodeT op);
	aluOpT a;
	case (op)
		OpAdd:   a = aluAdd;
		OpSub:   a = aluSub;
		OpOr:    a = aluOr;
		OpAnd:   a = aluAnd;
		default: a = aluPass;  // LOAD moves the operand unchanged
	endcase
	return a;
endfunction

////////////////////////////////////////
// Expected steps of one accepted instruction
////////////////////////////////////////

function automatic expListT expectedSteps(input instrT ins);
	expListT l;
	stepT    s;
	logic    ind;
	logic    imm;
	logic    modeLegal;
	l         = '0;
	ind       = (ins.flag == FlInd);
	imm       = (ins.flag == FlImm);
	modeLegal = (ins.flag == FlDir) || ind || imm;
	case (ins.opcode)
		OpAdd, OpSub, OpOr, OpAnd, OpLoad: begin
			if (modeLegal) begin
				if (ind) l = appendStep(l, memStep(1'b0, 1'b1, 1'b0));
				if (!imm) l = appendStep(l, memStep(1'b0, !ind, 1'b0));
				s = waitStep(endOne);
				s.word.accWrite   = 1'b1;
				s.word.aluOp      = aluFor(ins.opcode);
				s.word.operandImm = imm;
				l = appendStep(l, s);
			end
		end
		OpStor: begin
			if (modeLegal && !imm) begin
				if (ind) l = appendStep(l, memStep(1'b0, 1'b1, 1'b0));
				l = appendStep(l, memStep(1'b1, !ind, 1'b0));
			end
		end
		OpShft: begin
			if (ins.flag inside {FlLs0, FlLs1, FlRs0, FlRs1}) begin
				s = waitStep(endOne);
				s.word.shiftEn    = 1'b1;
				s.word.shiftRight = (ins.flag == FlRs0) || (ins.flag == FlRs1);
				s.word.shiftFill  = (ins.flag == FlLs1) || (ins.flag == FlRs1);
				l = appendStep(l, s);
			end
		end
		OpInput: begin
			if (modeLegal && !imm) begin
				l = appendStep(l, waitStep(endInRdy));
				if (ind) l = appendStep(l, memStep(1'b0, 1'b1, 1'b0));
				l = appendStep(l, memStep(1'b1, !ind, 1'b1));
				s = waitStep(endOne);
				s.inPulse = 1'b1;  // Device gets its receive strobe
				l = appendStep(l, s);
			end
		end
		OpOutput: begin
			if (ins.flag == FlDir) begin
				l = appendStep(l, waitStep(endOutRdy));
				l = appendStep(l, memStep(1'b0, 1'b1, 1'b0));
				s = waitStep(endOutRecv);
				s.word.outLoad = 1'b1;
				l = appendStep(l, s);
			end
		end
		default: l = '0;  // NOP and dropped codes
	endcase
	return l;
endfunction

`endif

/* bench/stageOneCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module stageOneCtrlTb import stageOnePkg::*; ();

	localparam int NumInstr   = 200;
	localparam int CycleLimit = NumInstr * 60;
	localparam int BurstMax   = 12;  // Eleven misses plus the forced cycle

	`include "stageOneModel.svh"

	logic       clk;
	logic       rstN;
	instrT      instr;
	logic       stg0State;
	byteT       irData;
	logic       cacheHit;
	logic       inputRdy;
	logic       outDevRdy;
	logic       outRecv;
	logic       stg1State;
	ctrlWordT   ctrl;
	shiftCountT numShift;
	logic       inputRecv;

	expListT    expList;
	stepT       step;
	logic [2:0] stepIdx;
	int         stepCycles;
	logic       busy;
	logic       stepDone;
	int         accepted   = 0;
	int         cycleCount = 0;

	stageOneCtrl u_stageOneCtrl (
		.clk       (clk),
		.rstN      (rstN),
		.instr     (instr),
		.stg0State (stg0State),
		.irData    (irData),
		.cacheHit  (cacheHit),
		.inputRdy  (inputRdy),
		.outDevRdy (outDevRdy),
		.outRecv   (outRecv),
		.stg1State (stg1State),
		.ctrl      (ctrl),
		.numShift  (numShift),
		.inputRecv (inputRecv)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic instrT randomInstr();
		instrT ins;
		case ($urandom_range(11, 0))
			0:       ins.opcode = OpAdd;
			1:       ins.opcode = OpSub;
			2:       ins.opcode = OpOr;
			3:       ins.opcode = OpAnd;
			4:       ins.opcode = OpShft;
			5:       ins.opcode = OpLoad;
			6:       ins.opcode = OpStor;
			7:       ins.opcode = OpInput;
			8:       ins.opcode = OpOutput;
			9:       ins.opcode = OpNop;
			default: ins.opcode = opcodeT'($urandom_range(31, 16));  // Dropped codes
		endcase
		ins.flag = ($urandom_range(3, 0) == 0) ? flagT'($urandom_range(7, 3))
		                                       : flagT'($urandom_range(3, 0));
		return ins;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expVal,
	                          input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("ERR %s expected %0h actual %0h", name, expVal, actVal);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkIdle(input string name);
		checkValue({name, " stg1State"}, 32'd1, 32'(stg1State));
		checkValue({name, " ctrl"}, 32'd0, 32'(ctrl));
		checkValue({name, " numShift"}, 32'd0, 32'(numShift));
		checkValue({name, " inputRecv"}, 32'd0, 32'(inputRecv));
	endtask

	////////////////////////////////////////
	// Stimulus, driven on the rising edge
	////////////////////////////////////////

	initial begin
		rstN      <= 1'b0;
		instr     <= '0;
		stg0State <= 1'b0;
		irData    <= '0;
		cacheHit  <= 1'b0;
		inputRdy  <= 1'b0;
		outDevRdy <= 1'b0;
		outRecv   <= 1'b0;
		void'($urandom(61));
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		forever begin
			@(posedge clk);
			stg0State <= (accepted < NumInstr) && ($urandom_range(3, 0) != 0);
			instr     <= randomInstr();
			irData    <= byteT'($urandom());
			cacheHit  <= ($urandom_range(2, 0) == 0);
			inputRdy  <= ($urandom_range(2, 0) == 0);
			outDevRdy <= ($urandom_range(2, 0) == 0);
			outRecv   <= ($urandom_range(2, 0) == 0);
		end
	end

	// One falling-edge sample, walked against the expected steps
	task automatic sampleCycle();
		string tag;
		tag = $sformatf("instr %0d step %0d", accepted, stepIdx);
		if (!busy) begin
			checkIdle({tag, " idle"});
			if (stg0State) begin
				expList    = expectedSteps(instr);
				stepIdx    = 3'd0;
				stepCycles = 0;
				busy       = (expList.count != 3'd0);  // NOP is back at once
				accepted++;
			end
		end else begin
			step = expList.steps[stepIdx];
			stepCycles++;
			checkValue({tag, " stg1State"}, 32'd0, 32'(stg1State));
			checkValue({tag, " ctrl"}, 32'(step.word), 32'(ctrl));
			checkValue({tag, " numShift"}, 32'(step.word.shiftEn ? irData[2:0] : 3'd0),
			           32'(numShift));
			checkValue({tag, " inputRecv"}, 32'(step.inPulse), 32'(inputRecv));
			case (step.stepEnd)
				endCache:   stepDone = cacheHit || (stepCycles == BurstMax);
				endInRdy:   stepDone = inputRdy;
				endOutRdy:  stepDone = outDevRdy;
				endOutRecv: stepDone = outRecv;
				default:    stepDone = 1'b1;
			endcase
			if (stepDone) begin
				stepIdx    = stepIdx + 3'd1;
				stepCycles = 0;
				busy       = (stepIdx != expList.count);
			end
		end
	endtask

	initial begin
		busy    = 1'b0;
		stepIdx = 3'd0;
		wait (rstN === 1'b1);
		@(negedge clk);
		checkIdle("reset");
		while (accepted < NumInstr || busy) begin
			@(negedge clk);
			sampleCycle();
		end
		$display("Test OK");
		$finish;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > CycleLimit) begin
			$display("Run hung with %0d of %0d instructions accepted after %0d cycles",
			         accepted, NumInstr, CycleLimit);
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* design/stageOneCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module stageOneCtrl import stageOnePkg::*; (
	input  wire        clk,
	input  wire        rstN,
	input  instrT      instr,
	input  wire        stg0State,
	input  byteT       irData,
	input  wire        cacheHit,
	input  wire        inputRdy,
	input  wire        outDevRdy,
	input  wire        outRecv,
	output logic       stg1State,
	output ctrlWordT   ctrl,
	output shiftCountT numShift,
	output logic       inputRecv
);

	instrT        instrLatched;
	decodedInstrT decoded;
	seqPhaseT     phase;
	logic         accessDone;

	instrDecode u_instrDecode (
		.instr   (instrLatched),
		.decoded (decoded)
	);

	cacheWait u_cacheWait (
		.clk        (clk),
		.rstN       (rstN),
		.phase      (phase),
		.cacheHit   (cacheHit),
		.accessDone (accessDone)
	);

	stageSequencer u_stageSequencer (
		.clk          (clk),
		.rstN         (rstN),
		.instr        (instr),
		.stg0State    (stg0State),
		.decoded      (decoded),
		.accessDone   (accessDone),
		.inputRdy     (inputRdy),
		.outDevRdy    (outDevRdy),
		.outRecv      (outRecv),
		.instrLatched (instrLatched),
		.phase        (phase),
		.stg1State    (stg1State),
		.inputRecv    (inputRecv)
	);

	ctrlWordGen u_ctrlWordGen (
		.phase    (phase),
		.decoded  (decoded),
		.irData   (irData),
		.ctrl     (ctrl),
		.numShift (numShift)
	);

endmodule

`default_nettype wire

/* design/ctrlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrlWordGen import stageOnePkg::*; (
	input  seqPhaseT     phase,
	input  decodedInstrT decoded,
	input  byteT         irData,
	output ctrlWordT     ctrl,
	output shiftCountT   numShift
);

	logic viaPointer;  // Address taken from the fetched pointer

	assign viaPointer = (decoded.addrMode == modeInd);

	always_comb begin
		ctrl     = '0;
		numShift = '0;
		case (phase)
			phFetchPtr: begin
				ctrl.memRead    = 1'b1;
				ctrl.addrFromIr = 1'b1;
			end
			phFetchOpnd: begin
				ctrl.memRead    = 1'b1;
				ctrl.addrFromIr = !viaPointer;
			end
			phStore: begin
				ctrl.memWrite   = 1'b1;
				ctrl.addrFromIr = !viaPointer;
				ctrl.inSelect   = (decoded.opClass == clsInput);
			end
			phExec: begin
				ctrl.accWrite   = 1'b1;
				ctrl.aluOp      = decoded.aluOp;
				ctrl.operandImm = (decoded.addrMode == modeImm);
			end
			phShift: begin
				ctrl.shiftEn    = 1'b1;
				ctrl.shiftRight = decoded.shiftRight;
				ctrl.shiftFill  = decoded.shiftFill;
				numShift        = irData[2:0];  // Count from the operand byte
			end
			phOutHold: ctrl.outLoad = 1'b1;
			default: begin
				ctrl     = '0;
				numShift = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/stageSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stageSequencer import stageOnePkg::*; (
	input  wire          clk,
	input  wire          rstN,
	input  instrT        instr,
	input  wire          stg0State,
	input  decodedInstrT decoded,
	input  wire          accessDone,
	input  wire          inputRdy,
	input  wire          outDevRdy,
	input  wire          outRecv,
	output instrT        instrLatched,
	output seqPhaseT     phase,
	output logic         stg1State,
	output logic         inputRecv
);

	instrT    instrReg;
	seqPhaseT phaseNext;
	logic     accept;

	assign stg1State = (phase == phIdle);
	assign accept    = stg1State && stg0State;
	assign inputRecv = (phase == phInDone);

	// While idle the decoder sees stage 0 so the first phase is known at acceptance
	assign instrLatched = stg1State ? instr : instrReg;

	always_ff @(posedge clk) begin
		if (accept) begin
			instrReg <= instr;
		end
	end

	////////////////////////////////////////
	// Phase sequencing
	////////////////////////////////////////

	always_comb begin
		phaseNext = phase;
		case (phase)
			phIdle: begin
				if (accept) begin
					case (decoded.opClass)
						clsAlu, clsLoad: begin
							case (decoded.addrMode)
								modeInd: phaseNext = phFetchPtr;
								modeImm: phaseNext = phExec;
								default: phaseNext = phFetchOpnd;
							endcase
						end
						clsStore:  phaseNext = (decoded.addrMode == modeInd) ? phFetchPtr : phStore;
						clsShift:  phaseNext = phShift;
						clsInput:  phaseNext = phWaitIn;
						clsOutput: phaseNext = phWaitOut;
						default:   phaseNext = phIdle;  // NOP stays idle
					endcase
				end
			end
			phWaitIn: begin
				if (inputRdy) begin
					phaseNext = (decoded.addrMode == modeInd) ? phFetchPtr : phStore;
				end
			end
			phWaitOut: begin
				if (outDevRdy) begin
					phaseNext = phFetchOpnd;
				end
			end
			phFetchPtr: begin
				if (accessDone) begin
					if (decoded.opClass inside {clsStore, clsInput}) begin
						phaseNext = phStore;
					end else begin
						phaseNext = phFetchOpnd;
					end
				end
			end
			phFetchOpnd: begin
				if (accessDone) begin
					phaseNext = (decoded.opClass == clsOutput) ? phOutHold : phExec;
				end
			end
			phStore: begin
				if (accessDone) begin
					phaseNext = (decoded.opClass == clsInput) ? phInDone : phIdle;
				end
			end
			phOutHold: begin
				if (outRecv) begin
					phaseNext = phIdle;  // Device took the byte
				end
			end
			phExec, phShift, phInDone: phaseNext = phIdle;
			default: phaseNext = phIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phase <= phIdle;
		end else begin
			phase <= phaseNext;
		end
	end

endmodule

`default_nettype wire

/* design/cacheWait.sv */
`timescale 1ns/1ps
`default_nettype none

module cacheWait import stageOnePkg::*; (
	input  wire      clk,
	input  wire      rstN,
	input  seqPhaseT phase,
	input  wire      cacheHit,
	output logic     accessDone
);

	missCountT missCount;
	logic      memPhase;

	assign memPhase = phase inside {phFetchPtr, phFetchOpnd, phStore};

	// Hit ends the access, else the twelfth cycle forces it
	assign accessDone = memPhase && (cacheHit || missCount == MissLimit);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			missCount <= '0;
		end else if (!memPhase || accessDone) begin
			missCount <= '0;  // Fresh count for the next access
		end else begin
			missCount <= missCount + 4'd1;
		end
	end

endmodule

`default_nettype wire

/* design/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode import stageOnePkg::*; (
	input  instrT        instr,
	output decodedInstrT decoded
);

	addrModeT mode;
	logic     modeOk;  // Flag is dir, ind or imm

	always_comb begin
		modeOk = 1'b1;
		case (instr.flag)
			FlDir: mode = modeDir;
			FlInd: mode = modeInd;
			FlImm: mode = modeImm;
			default: begin
				mode   = modeDir;
				modeOk = 1'b0;
			end
		endcase
	end

	always_comb begin
		decoded            = '0;
		decoded.opClass    = clsNop;   // Anything unmatched falls to NOP
		decoded.aluOp      = aluPass;
		decoded.addrMode   = mode;
		case (instr.opcode)
			OpAdd: if (modeOk) begin
				decoded.opClass = clsAlu;
				decoded.aluOp   = aluAdd;
			end
			OpSub: if (modeOk) begin
				decoded.opClass = clsAlu;
				decoded.aluOp   = aluSub;
			end
			OpOr: if (modeOk) begin
				decoded.opClass = clsAlu;
				decoded.aluOp   = aluOr;
			end
			OpAnd: if (modeOk) begin
				decoded.opClass = clsAlu;
				decoded.aluOp   = aluAnd;
			end
			OpLoad: if (modeOk) decoded.opClass = clsLoad;
			OpStor: if (mode != modeImm && modeOk) decoded.opClass = clsStore;
			OpInput: if (mode != modeImm && modeOk) decoded.opClass = clsInput;
			OpOutput: if (instr.flag == FlDir) decoded.opClass = clsOutput;
			OpShft: begin
				decoded.addrMode = modeDir;
				if (instr.flag inside {FlLs0, FlLs1, FlRs0, FlRs1}) begin
					decoded.opClass    = clsShift;
					decoded.shiftRight = instr.flag inside {FlRs0, FlRs1};
					decoded.shiftFill  = instr.flag inside {FlLs1, FlRs1};
				end
			end
			OpNop:   decoded.opClass = clsNop;
			default: decoded.opClass = clsNop;
		endcase
	end

endmodule

`default_nettype wire

/* design/stageOnePkg.sv */
`default_nettype none

package stageOnePkg;

	////////////////////////////////////////
	// Field and datapath widths
	////////////////////////////////////////

	typedef logic [7:0] byteT;       // Operand byte from IR data
	typedef logic [4:0] opcodeT;
	typedef logic [2:0] flagT;       // Addressing or shift flag
	typedef logic [2:0] shiftCountT;
	typedef logic [3:0] missCountT;

	typedef struct packed {
		opcodeT opcode;
		flagT   flag;
	} instrT;

	localparam missCountT MissLimit = 4'd11; // Misses before a forced end

	// Opcode map of the processor
	localparam opcodeT OpAdd    = 5'b00000;
	localparam opcodeT OpSub    = 5'b00001;
	localparam opcodeT OpOr     = 5'b00011;
	localparam opcodeT OpAnd    = 5'b00100;
	localparam opcodeT OpShft   = 5'b00101;
	localparam opcodeT OpLoad   = 5'b01010;
	localparam opcodeT OpStor   = 5'b01011;
	localparam opcodeT OpInput  = 5'b01100;
	localparam opcodeT OpOutput = 5'b01101;
	localparam opcodeT OpNop    = 5'b01111;

	localparam flagT FlDir = 3'd0;
	localparam flagT FlInd = 3'd1;
	localparam flagT FlImm = 3'd2;
	localparam flagT FlLs0 = 3'd0;   // Shift flags share the field
	localparam flagT FlLs1 = 3'd1;
	localparam flagT FlRs0 = 3'd2;
	localparam flagT FlRs1 = 3'd3;

	////////////////////////////////////////
	// Decode and control types
	////////////////////////////////////////

	typedef enum logic [2:0] {
		clsAlu, clsLoad, clsStore, clsShift, clsInput, clsOutput, clsNop
	} opClassT;

	typedef enum logic [1:0] {modeDir, modeInd, modeImm} addrModeT;

	typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluOr, aluAnd} aluOpT;

	typedef struct packed {
		opClassT  opClass;
		aluOpT    aluOp;
		addrModeT addrMode;
		logic     shiftRight;
		logic     shiftFill;
	} decodedInstrT;

	typedef enum logic [3:0] {
		phIdle, phFetchPtr, phFetchOpnd, phStore, phWaitIn,
		phWaitOut, phExec, phShift, phOutHold, phInDone
	} seqPhaseT;

	typedef struct packed {
		aluOpT aluOp;
		logic  accWrite;
		logic  memRead;
		logic  memWrite;
		logic  addrFromIr;  // 0 selects the fetched pointer
		logic  operandImm;
		logic  shiftEn;
		logic  shiftRight;
		logic  shiftFill;
		logic  outLoad;
		logic  inSelect;    // Input device data onto the write bus
	} ctrlWordT;

endpackage

`default_nettype wire
